/* common/audio_pkg.sv */
package audio_pkg;

	// ----------------------------------------------------------------------
	// sample format.
	// ----------------------------------------------------------------------
	localparam int SAMPLE_WIDTH = 24;
	localparam int FILTER_DEPTH = 16;

	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	localparam sample_t SAMPLE_MAX = 24'sh7f_ffff;
	localparam sample_t SAMPLE_MIN = 24'sh80_0000;

	typedef struct packed {
		logic    valid;
		sample_t data;
	} audio_stream_t;

	// one shift-and-add response per mode, see lowpass_filter.
	typedef enum logic [2:0] {
		lp_2tap  = 3'd0,
		lp_blend = 3'd1,
		lp_4tap  = 3'd2,
		lp_6tap  = 3'd3,
		lp_7tap  = 3'd4,
		lp_10tap = 3'd5,
		lp_12tap = 3'd6,
		lp_16tap = 3'd7
	} filter_mode_e;

	// gain is unsigned, 128 is unity.
	localparam logic [7:0] GAIN_UNITY = 8'd128;
	localparam int         GAIN_SHIFT = 7;

	typedef struct packed {
		filter_mode_e mode;
		logic         bypass;
		logic [7:0]   gain;
	} channel_ctrl_t;

	// ----------------------------------------------------------------------
	// wishbone classic and register map.
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	localparam logic [3:0] REG_CTRL    = 4'h0;
	localparam logic [3:0] REG_GAIN    = 4'h4;
	localparam logic [3:0] REG_SAMPLES = 4'h8;
	localparam logic [3:0] REG_CLIPS   = 4'hc;

endpackage

/* filter/lowpass_filter.sv */
module lowpass_filter (
	input  logic                   clk,
	input  logic                   reset_n,
	input  audio_pkg::audio_stream_t sample_in,
	input  audio_pkg::filter_mode_e  mode,
	input  logic                   bypass,
	output audio_pkg::audio_stream_t filtered
);

	import audio_pkg::*;

	// a few guard bits over the sample width for the adder tree.
	localparam int ACC_WIDTH = SAMPLE_WIDTH + 4;

	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	sample_t delay_line [FILTER_DEPTH];
	logic    tap_valid;
	logic    sum_valid;
	acc_t    sum_acc;

	// ----------------------------------------------------------------------
	// ladder response.
	// taps 0 and 1 take the top shift, every older tap one less,
	// ending at shift 1 on the oldest tap. weights add up to one.
	// ----------------------------------------------------------------------
	function automatic acc_t ladder_sum(
		input sample_t     taps [FILTER_DEPTH],
		input int unsigned n_taps
	);
		acc_t        acc;
		int unsigned shift;
		acc = '0;
		for (int i = 0; i < FILTER_DEPTH; i++) begin
			if (i < n_taps) begin
				shift = (i == 0) ? n_taps - 1 : n_taps - i;
				acc   = acc + acc_t'(taps[i] >>> shift);
			end
		end
		return acc;
	endfunction

	// blend puts 3/4 on the newest sample and 1/4 on the one before.
	function automatic acc_t blend_sum(input sample_t taps [FILTER_DEPTH]);
		acc_t acc;
		acc = acc_t'(taps[0] >>> 2) + acc_t'(taps[1] >>> 2);
		acc = acc + acc_t'(taps[0] >>> 1);
		return acc;
	endfunction

	// ----------------------------------------------------------------------
	// delay line.
	// ----------------------------------------------------------------------
	// moves only on a valid input.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < FILTER_DEPTH; i++) begin
				delay_line[i] <= '0;
			end
		end else if (sample_in.valid) begin
			delay_line[0] <= sample_in.data;
			for (int i = 1; i < FILTER_DEPTH; i++) begin
				delay_line[i] <= delay_line[i-1];
			end
		end
	end

	// valid follows the sample through both stages.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tap_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			tap_valid <= sample_in.valid;
			sum_valid <= tap_valid;
		end
	end

	// ----------------------------------------------------------------------
	// sum stage.
	// ----------------------------------------------------------------------
	// mode is sampled here, so a change hits the next sum only.
	always_ff @(posedge clk) begin
		if (tap_valid) begin
			if (bypass) begin
				// same stage as the filter so latency does not move.
				sum_acc <= acc_t'(delay_line[0]);
			end else begin
				unique case (mode)
					lp_2tap:  sum_acc <= ladder_sum(delay_line, 2);
					lp_blend: sum_acc <= blend_sum(delay_line);
					lp_4tap:  sum_acc <= ladder_sum(delay_line, 4);
					lp_6tap:  sum_acc <= ladder_sum(delay_line, 6);
					lp_7tap:  sum_acc <= ladder_sum(delay_line, 7);
					lp_10tap: sum_acc <= ladder_sum(delay_line, 10);
					lp_12tap: sum_acc <= ladder_sum(delay_line, 12);
					lp_16tap: sum_acc <= ladder_sum(delay_line, 16);
				endcase
			end
		end
	end

	// unity gain response, the top bits are sign only.
	assign filtered.valid = sum_valid;
	assign filtered.data  = sum_acc[SAMPLE_WIDTH-1:0];

	// mode comes from the register block and must be settled.
	mode_known_a: assert property (
		@(posedge clk) disable iff (!reset_n)
		tap_valid |-> !$isunknown(mode)
	);

endmodule

/* source/control_regs.sv */
module control_regs (
	input  logic                  clk,
	input  logic                  reset_n,
	input  audio_pkg::wb_req_t     wb_req,
	input  logic                  sample_event,
	input  logic                  clip_event,
	output audio_pkg::wb_rsp_t     wb_rsp,
	output audio_pkg::channel_ctrl_t ctrl
);

	import audio_pkg::*;

	typedef enum logic [1:0] {
		sel_ctrl    = REG_CTRL[3:2],
		sel_gain    = REG_GAIN[3:2],
		sel_samples = REG_SAMPLES[3:2],
		sel_clips   = REG_CLIPS[3:2]
	} reg_sel_e;

	reg_sel_e      sel;
	logic          access;
	logic          wr;
	logic          ack_q;
	logic [31:0]   rd_data;
	logic [31:0]   rd_q;
	logic [31:0]   sample_count;
	logic [31:0]   clip_count;
	channel_ctrl_t ctrl_q;

	assign sel = reg_sel_e'(wb_req.adr[3:2]);

	// a new request is taken only while ack is low.
	assign access = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr     = access && wb_req.we;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// ----------------------------------------------------------------------
	// control registers.
	// ----------------------------------------------------------------------
	// written on the same edge that raises ack.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ctrl_q <= '{mode: lp_2tap, bypass: 1'b0, gain: GAIN_UNITY};
		end else if (wr && sel == sel_ctrl) begin
			ctrl_q.mode   <= filter_mode_e'(wb_req.dat[2:0]);
			ctrl_q.bypass <= wb_req.dat[3];
		end else if (wr && sel == sel_gain) begin
			ctrl_q.gain <= wb_req.dat[7:0];
		end
	end

	// ----------------------------------------------------------------------
	// event counters.
	// ----------------------------------------------------------------------
	// a write clears the counter but an event in the same cycle still counts.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			sample_count <= '0;
			clip_count   <= '0;
		end else begin
			if (wr && sel == sel_samples) begin
				sample_count <= 32'(sample_event);
			end else begin
				sample_count <= sample_count + 32'(sample_event);
			end
			if (wr && sel == sel_clips) begin
				clip_count <= 32'(clip_event);
			end else begin
				clip_count <= clip_count + 32'(clip_event);
			end
		end
	end

	always_comb begin
		unique case (sel)
			sel_ctrl:    rd_data = {28'd0, ctrl_q.bypass, ctrl_q.mode};
			sel_gain:    rd_data = {24'd0, ctrl_q.gain};
			sel_samples: rd_data = sample_count;
			sel_clips:   rd_data = clip_count;
		endcase
	end

	// read data lines up with ack.
	always_ff @(posedge clk) begin
		if (access) begin
			rd_q <= rd_data;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rd_q;
	assign ctrl       = ctrl_q;

	// ack only answers a held request and never repeats on the next cycle.
	single_ack_a: assert property (
		@(posedge clk) disable iff (!reset_n)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb && !$past(wb_rsp.ack))
	);

endmodule

/* source/volume_stage.sv */
module volume_stage (
	input  logic                   clk,
	input  logic                   reset_n,
	input  audio_pkg::audio_stream_t filtered,
	input  logic [7:0]             gain,
	output audio_pkg::audio_stream_t sample_out,
	output logic                   sample_event,
	output logic                   clip_event
);

	import audio_pkg::*;

	localparam int PROD_WIDTH = SAMPLE_WIDTH + 9;

	logic signed [PROD_WIDTH-1:0] product;
	logic signed [PROD_WIDTH-1:0] scaled;
	sample_t                      limited;
	logic                         clip;
	logic                         out_valid;
	sample_t                      out_data;

	// unsigned gain gets a zero sign bit.
	assign product = filtered.data * $signed({1'b0, gain});
	assign scaled  = product >>> GAIN_SHIFT;

	// saturate to the sample range.
	always_comb begin
		clip    = 1'b0;
		limited = scaled[SAMPLE_WIDTH-1:0];
		if (scaled > SAMPLE_MAX) begin
			clip    = 1'b1;
			limited = SAMPLE_MAX;
		end else if (scaled < SAMPLE_MIN) begin
			clip    = 1'b1;
			limited = SAMPLE_MIN;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			out_valid    <= 1'b0;
			sample_event <= 1'b0;
			clip_event   <= 1'b0;
		end else begin
			out_valid    <= filtered.valid;
			sample_event <= filtered.valid;
			clip_event   <= filtered.valid && clip;
		end
	end

	always_ff @(posedge clk) begin
		if (filtered.valid) begin
			out_data <= limited;
		end
	end

	assign sample_out.valid = out_valid;
	assign sample_out.data  = out_data;

	// the filter has unity gain, so a clip needs gain above unity.
	// a clip is always also a counted output sample.
	clip_has_sample_a: assert property (
		@(posedge clk) disable iff (!reset_n)
		clip_event |-> (sample_event && $past(gain) > GAIN_UNITY)
	);

endmodule

/* source/audio_channel_top.sv */
module audio_channel_top (
	input  logic                   clk,
	input  logic                   reset_n,
	input  audio_pkg::wb_req_t      wb_req,
	input  audio_pkg::audio_stream_t sample_in,
	output audio_pkg::wb_rsp_t      wb_rsp,
	output audio_pkg::audio_stream_t sample_out
);

	import audio_pkg::*;

	audio_stream_t filtered;
	channel_ctrl_t ctrl;
	logic          sample_event;
	logic          clip_event;

	// ----------------------------------------------------------------------
	// datapath.
	// ----------------------------------------------------------------------
	// two cycles in the filter.
	lowpass_filter u_filter (
		.clk       (clk),
		.reset_n   (reset_n),
		.sample_in (sample_in),
		.mode      (ctrl.mode),
		.bypass    (ctrl.bypass),
		.filtered  (filtered)
	);

	// one cycle for gain and saturation.
	volume_stage u_volume (
		.clk          (clk),
		.reset_n      (reset_n),
		.filtered     (filtered),
		.gain         (ctrl.gain),
		.sample_out   (sample_out),
		.sample_event (sample_event),
		.clip_event   (clip_event)
	);

	// ----------------------------------------------------------------------
	// register block.
	// ----------------------------------------------------------------------
	control_regs u_regs (
		.clk          (clk),
		.reset_n      (reset_n),
		.wb_req       (wb_req),
		.sample_event (sample_event),
		.clip_event   (clip_event),
		.wb_rsp       (wb_rsp),
		.ctrl         (ctrl)
	);

endmodule

/* verification/audio_channel_tb.sv */
module audio_channel_tb;

	import audio_pkg::*;

	localparam int ACK_LIMIT   = 20;
	localparam int DRAIN_LIMIT = 40;

	logic          clk;
	logic          reset_n;
	wb_req_t       wb_req;
	wb_rsp_t       wb_rsp;
	audio_stream_t sample_in;
	audio_stream_t sample_out;

	// shadow of the control registers, used by the model.
	filter_mode_e  cur_mode;
	logic          cur_bypass;
	logic [7:0]    cur_gain;

	// model state, owned by the output monitor.
	sample_t       hist [FILTER_DEPTH];
	logic [2:0]    pipe_v;
	sample_t       pipe_d [3];
	sample_t       model_filt;
	logic          model_clip;
	int            mon_errors;
	int            mon_checks;
	int            clip_expect;

	logic [31:0]   rng_state;
	int            error_count;
	int            check_count;
	int            tests_run;
	int            sent_count;

	audio_channel_top dut (
		.clk        (clk),
		.reset_n    (reset_n),
		.wb_req     (wb_req),
		.sample_in  (sample_in),
		.wb_rsp     (wb_rsp),
		.sample_out (sample_out)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// reference model.
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// ladder modes use the top shift on taps 0 and 1 and one less per older tap.
	function automatic int tap_shift(input filter_mode_e m, input int idx);
		int n;
		case (m)
			lp_2tap:  n = 2;
			lp_4tap:  n = 4;
			lp_6tap:  n = 6;
			lp_7tap:  n = 7;
			lp_10tap: n = 10;
			lp_12tap: n = 12;
			lp_16tap: n = 16;
			default:  n = 0;
		endcase
		if (idx >= n) begin
			return -1;
		end
		if (idx <= 1) begin
			return n - 1;
		end
		return (n - 1) - (idx - 1);
	endfunction

	function automatic sample_t filter_ref(input filter_mode_e m, input logic byp);
		int acc;
		int s;
		acc = 0;
		if (byp) begin
			return hist[0];
		end
		if (m == lp_blend) begin
			acc = (int'(hist[0]) >>> 2) + (int'(hist[1]) >>> 2) + (int'(hist[0]) >>> 1);
		end else begin
			for (int i = 0; i < FILTER_DEPTH; i++) begin
				s = tap_shift(m, i);
				if (s > 0) begin
					acc = acc + (int'(hist[i]) >>> s);
				end
			end
		end
		return sample_t'(acc);
	endfunction

	// gain of 128 is unity and the result clamps to the 24-bit range.
	function automatic sample_t gain_ref(input sample_t x, input logic [7:0] g,
			output logic clipped);
		longint scaled;
		scaled  = (longint'(x) * longint'(g)) >>> 7;
		clipped = 1'b0;
		if (scaled > 8388607) begin
			clipped = 1'b1;
			scaled  = 8388607;
		end else if (scaled < -8388608) begin
			clipped = 1'b1;
			scaled  = -8388608;
		end
		return sample_t'(scaled);
	endfunction

	// output must match the input seen three negedges earlier.
	always @(negedge clk) begin
		if (!reset_n) begin
			pipe_v = '0;
			for (int i = 0; i < FILTER_DEPTH; i++) begin
				hist[i] = '0;
			end
		end else begin
			if (sample_out.valid !== pipe_v[2]) begin
				mon_errors++;
				$display("Error at %0t: output valid is %b, expected %b",
					$time, sample_out.valid, pipe_v[2]);
			end else if (pipe_v[2]) begin
				mon_checks++;
				if (sample_out.data !== pipe_d[2]) begin
					mon_errors++;
					$display("Error at %0t: output sample %0d, expected %0d",
						$time, sample_out.data, pipe_d[2]);
				end
			end
			pipe_v    = {pipe_v[1:0], sample_in.valid};
			pipe_d[2] = pipe_d[1];
			pipe_d[1] = pipe_d[0];
			if (sample_in.valid) begin
				for (int i = FILTER_DEPTH - 1; i > 0; i--) begin
					hist[i] = hist[i-1];
				end
				hist[0]    = sample_in.data;
				model_filt = filter_ref(cur_mode, cur_bypass);
				pipe_d[0]  = gain_ref(model_filt, cur_gain, model_clip);
				if (model_clip) begin
					clip_expect++;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// bus and stream tasks.
	// ----------------------------------------------------------------------
	task automatic stop_on_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: data};
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_rsp.ack && waited < ACK_LIMIT);
		if (!wb_rsp.ack) begin
			stop_on_timeout("ack on a wishbone write");
		end
		@(posedge clk);
		wb_req <= '0;
		if (adr == REG_CTRL) begin
			cur_mode   = filter_mode_e'(data[2:0]);
			cur_bypass = data[3];
		end else if (adr == REG_GAIN) begin
			cur_gain = data[7:0];
		end
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
		int waited;
		waited = 0;
		@(posedge clk);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_rsp.ack && waited < ACK_LIMIT);
		if (!wb_rsp.ack) begin
			stop_on_timeout("ack on a wishbone read");
		end
		data = wb_rsp.dat;
		@(posedge clk);
		wb_req <= '0;
	endtask

	task automatic expect_reg(input logic [3:0] adr, input logic [31:0] exp, input string name);
		logic [31:0] got;
		wb_read(adr, got);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s reads %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	function automatic sample_t next_sample(input logic full);
		rng_state = xorshift(rng_state);
		if (full) begin
			return $signed(rng_state[23:0]);
		end
		return $signed(rng_state[23:0]) >>> 1;
	endfunction

	task automatic send_sample(input sample_t data);
		@(posedge clk);
		sample_in <= '{valid: 1'b1, data: data};
		sent_count++;
	endtask

	task automatic send_gap();
		@(posedge clk);
		sample_in <= '0;
	endtask

	// idle the input until every expected output has been compared.
	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		sample_in <= '0;
		do begin
			@(posedge clk);
			waited++;
		end while (pipe_v != 3'b000 && waited < DRAIN_LIMIT);
		if (pipe_v != 3'b000) begin
			stop_on_timeout("the sample pipeline to drain");
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("%s test finished, %0d errors", name, error_count + mon_errors - start);
	endtask

	// ----------------------------------------------------------------------
	// directed tests.
	// ----------------------------------------------------------------------
	task automatic test_registers();
		int start;
		start = error_count + mon_errors;
		expect_reg(REG_CTRL, 32'd0, "CTRL");
		expect_reg(REG_GAIN, 32'd128, "GAIN");
		expect_reg(REG_SAMPLES, 32'd0, "SAMPLES");
		expect_reg(REG_CLIPS, 32'd0, "CLIPS");
		// upper bits are not stored.
		wb_write(REG_CTRL, 32'h0000_00fb);
		expect_reg(REG_CTRL, 32'h0000_000b, "CTRL");
		wb_write(REG_GAIN, 32'h0000_015a);
		expect_reg(REG_GAIN, 32'h0000_005a, "GAIN");
		// bypassed full-scale samples at gain 255 all clip.
		wb_write(REG_GAIN, 32'd255);
		repeat (4) send_sample(SAMPLE_MAX);
		wait_drain();
		expect_reg(REG_SAMPLES, 32'd4, "SAMPLES");
		expect_reg(REG_CLIPS, 32'd4, "CLIPS");
		wb_write(REG_SAMPLES, 32'hffff_ffff);
		expect_reg(REG_SAMPLES, 32'd0, "SAMPLES");
		wb_write(REG_CLIPS, 32'h0000_1234);
		expect_reg(REG_CLIPS, 32'd0, "CLIPS");
		wb_write(REG_CTRL, 32'd0);
		wb_write(REG_GAIN, 32'd128);
		report_test("register", start);
	endtask

	task automatic test_impulse();
		int start;
		start = error_count + mon_errors;
		for (int m = 0; m < 8; m++) begin
			wb_write(REG_CTRL, 32'(m));
			repeat (FILTER_DEPTH) send_sample('0);
			send_sample(24'sd4194304);
			repeat (FILTER_DEPTH) send_sample('0);
			wait_drain();
		end
		report_test("impulse", start);
	endtask

	task automatic test_random();
		int start;
		start = error_count + mon_errors;
		for (int m = 0; m < 8; m++) begin
			wb_write(REG_CTRL, 32'(m));
			repeat (24) send_sample(next_sample(1'b0));
			wait_drain();
		end
		report_test("random burst", start);
	endtask

	task automatic test_bypass();
		int start;
		start = error_count + mon_errors;
		// bypass with the longest filter mode selected.
		wb_write(REG_CTRL, 32'h0000_000f);
		repeat (20) send_sample(next_sample(1'b0));
		wait_drain();
		// history from the bypassed samples feeds the next outputs.
		wb_write(REG_CTRL, 32'h0000_0007);
		repeat (20) send_sample(next_sample(1'b0));
		wait_drain();
		report_test("bypass", start);
	endtask

	task automatic test_saturation();
		int          start;
		int          clip_base;
		logic [31:0] clips;
		start = error_count + mon_errors;
		wb_write(REG_CTRL, 32'(lp_blend));
		wb_write(REG_GAIN, 32'd255);
		wb_write(REG_CLIPS, 32'd0);
		clip_base = clip_expect;
		repeat (32) send_sample(next_sample(1'b1));
		wait_drain();
		wb_read(REG_CLIPS, clips);
		check_count++;
		if (clips != 32'(clip_expect - clip_base)) begin
			error_count++;
			$display("Error at %0t: CLIPS reads %0d, expected %0d",
				$time, clips, clip_expect - clip_base);
		end
		if (clip_expect == clip_base) begin
			error_count++;
			$display("Saturation test produced no clipped samples at all");
		end
		wb_write(REG_GAIN, 32'd128);
		report_test("saturation", start);
	endtask

	task automatic test_sample_count();
		int      start;
		sample_t data;
		start = error_count + mon_errors;
		wb_write(REG_CTRL, 32'(lp_6tap));
		wb_write(REG_SAMPLES, 32'd0);
		sent_count = 0;
		for (int i = 0; i < 40; i++) begin
			data = next_sample(1'b0);
			if (rng_state[31]) begin
				send_sample(data);
			end else begin
				send_gap();
			end
		end
		wait_drain();
		expect_reg(REG_SAMPLES, 32'(sent_count), "SAMPLES");
		report_test("sample count", start);
	endtask

	initial begin
		reset_n     = 1'b0;
		wb_req      = '0;
		sample_in   = '0;
		cur_mode    = lp_2tap;
		cur_bypass  = 1'b0;
		cur_gain    = GAIN_UNITY;
		rng_state   = 32'd58044;
		error_count = 0;
		check_count = 0;
		tests_run   = 0;
		sent_count  = 0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
		test_registers();
		test_impulse();
		test_random();
		test_bypass();
		test_saturation();
		test_sample_count();
		$display("tests %0d, checks %0d, errors %0d", tests_run,
			check_count + mon_checks, error_count + mon_errors);
		if (error_count + mon_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* verilog.f */
common/audio_pkg.sv
filter/lowpass_filter.sv
source/control_regs.sv
source/volume_stage.sv
source/audio_channel_top.sv
verification/audio_channel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the audio channel testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module audio_channel_tb \
	-f verilog.f \
	-o audio_channel_sim

output=$(./obj_dir/audio_channel_sim)
echo "$output"

if echo "$output" | grep -qx "No errors"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
